/* core_ctrl_pkg.sv */
/*
 * core control definitions
 * bridge register map, soft reset hold length and the gamepad key
 * layout used to build the arcade control panel word
 */

package core_ctrl_pkg;

    // bridge address and data word
    typedef logic [31:0] bridge_data_t;

    // settings registers seen by the host
    typedef enum logic [31:0] {
        REG_RESET     = 32'hF000_0000,
        REG_DIP       = 32'hF100_0000,
        REG_MODE      = 32'hF200_0000,
        REG_SCANLINES = 32'hF300_0000
    } bridge_reg_e;

    // core held stopped for this many cycles after a reset request
    localparam int CORE_RESET_HOLD = 8000;
    localparam int RESET_CNT_W     = $clog2(CORE_RESET_HOLD + 1);

    // key bit positions in the pad key word
    localparam int PAD_UP     = 0;
    localparam int PAD_DOWN   = 1;
    localparam int PAD_LEFT   = 2;
    localparam int PAD_RIGHT  = 3;
    localparam int PAD_B      = 5;
    localparam int PAD_Y      = 7;
    localparam int PAD_SELECT = 14;
    localparam int PAD_START  = 15;

    // arcade control panel, msb first
    typedef struct packed {
        logic coin;
        logic start2;
        logic start1;
        logic shoot2;
        logic shoot;
        logic up;
        logic down;
        logic left;
        logic right;
    } panel_t;

endpackage

/* video_pkg.sv */
/*
 * video definitions
 * pixel widths, pixel types and scanline darkening levels
 */

package video_pkg;

    // bits per colour channel
    localparam int CHAN_IN_W  = 4;
    localparam int CHAN_OUT_W = 8;

    // packed r, g, b with red on top
    typedef logic [3*CHAN_IN_W-1:0]  rgb_in_t;
    typedef logic [3*CHAN_OUT_W-1:0] rgb_out_t;

    // darkening applied to odd lines
    typedef enum logic [1:0] {
        SCN_OFF = 2'd0,
        SCN_25  = 2'd1,
        SCN_50  = 2'd2,
        SCN_75  = 2'd3
    } scanline_level_e;

endpackage

/* video_if.sv */
/*
 * video pixel link
 * one pixel per cycle with its sync, data enable and line parity
 */

`timescale 1ns/1ps

interface video_if;
    import video_pkg::*;

    rgb_out_t rgb;
    logic     hs;
    logic     vs;
    logic     de;
    logic     odd_line;

    modport source (output rgb, output hs, output vs, output de, output odd_line);

    modport sink (input rgb, input hs, input vs, input de, input odd_line);

endinterface

/* bridge_regs.sv */
/*
 * bridge settings registers
 * decodes host reads and writes, keeps the dip, mode and scanline words
 * and asks for a core reset on writes to the reset or dip register
 */

`timescale 1ns/1ps

module bridge_regs (
    input  logic                       clk_74a,
    input  logic                       temp_reset,
    input  core_ctrl_pkg::bridge_data_t bridge_addr,
    input  logic                       bridge_rd,
    input  logic                       bridge_wr,
    input  core_ctrl_pkg::bridge_data_t bridge_wr_data,
    input  logic                       core_run,
    output core_ctrl_pkg::bridge_data_t bridge_rd_data,
    output core_ctrl_pkg::bridge_data_t dip_word,
    output logic [7:0]                 core_mode,
    output video_pkg::scanline_level_e scanline_level,
    output logic                       soft_reset_req
);
    import core_ctrl_pkg::*;
    import video_pkg::*;

    bridge_data_t mode_word;
    bridge_data_t scnl_word;
    logic         reset_hit;

    // reset command and dip change both restart the core
    assign reset_hit = bridge_wr && (bridge_addr == REG_RESET || bridge_addr == REG_DIP);

    //////////////////////////////////////////////////
    // host writes

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            dip_word       <= '0;
            mode_word      <= '0;
            scnl_word      <= '0;
            soft_reset_req <= 1'b0;
        end else begin
            soft_reset_req <= reset_hit;
            if (bridge_wr) begin
                case (bridge_addr)
                    REG_DIP:       dip_word  <= bridge_wr_data;
                    REG_MODE:      mode_word <= bridge_wr_data;
                    REG_SCANLINES: scnl_word <= bridge_wr_data;
                    // reset register holds no data, unmapped ignored
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // host reads, held until the next strobe

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            case (bridge_addr)
                REG_RESET:     bridge_rd_data <= {31'b0, core_run};
                REG_DIP:       bridge_rd_data <= dip_word;
                REG_MODE:      bridge_rd_data <= mode_word;
                REG_SCANLINES: bridge_rd_data <= scnl_word;
                default:       bridge_rd_data <= '0;
            endcase
        end
    end

    // settings as seen by the core
    assign core_mode      = mode_word[7:0];
    assign scanline_level = scanline_level_e'(scnl_word[1:0]);

endmodule

/* core_reset_timer.sv */
/*
 * core reset hold timer
 * keeps core_run low for a fixed hold after reset or a soft request
 */

`timescale 1ns/1ps

module core_reset_timer (
    input  logic clk_74a,
    input  logic temp_reset,
    input  logic soft_reset_req,
    output logic core_run
);
    import core_ctrl_pkg::*;

    logic [RESET_CNT_W-1:0] hold_cnt;

    always_ff @(posedge clk_74a) begin
        if (temp_reset || soft_reset_req) begin
            // restart the hold
            hold_cnt <= RESET_CNT_W'(CORE_RESET_HOLD);
            core_run <= 1'b0;
        end else if (hold_cnt == '0) begin
            core_run <= 1'b1;
        end else begin
            hold_cnt <= hold_cnt - 1'b1;
            core_run <= 1'b0;
        end
    end

endmodule

/* pad_merge.sv */
/*
 * gamepad merge
 * folds two pad key words into the active-low arcade control panel
 */

`timescale 1ns/1ps

module pad_merge (
    input  logic                        clk_74a,
    input  logic                        temp_reset,
    input  core_ctrl_pkg::bridge_data_t cont1_key,
    input  core_ctrl_pkg::bridge_data_t cont2_key,
    output core_ctrl_pkg::panel_t       control_panel
);
    import core_ctrl_pkg::*;

    panel_t pressed;

    //////////////////////////////////////////////////
    // active-high panel from both pads

    always_comb begin
        pressed.coin   = cont1_key[PAD_SELECT] | cont2_key[PAD_SELECT];
        // start buttons stay per player
        pressed.start2 = cont2_key[PAD_START];
        pressed.start1 = cont1_key[PAD_START];
        pressed.shoot2 = cont1_key[PAD_Y] | cont2_key[PAD_Y];
        pressed.shoot  = cont1_key[PAD_B] | cont2_key[PAD_B];
        // shared joystick
        pressed.up     = cont1_key[PAD_UP]    | cont2_key[PAD_UP];
        pressed.down   = cont1_key[PAD_DOWN]  | cont2_key[PAD_DOWN];
        pressed.left   = cont1_key[PAD_LEFT]  | cont2_key[PAD_LEFT];
        pressed.right  = cont1_key[PAD_RIGHT] | cont2_key[PAD_RIGHT];
    end

    // core expects pressed as 0
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            control_panel <= '1;
        end else begin
            control_panel <= ~pressed;
        end
    end

endmodule

/* video_line_stage.sv */
/*
 * video line stage
 * expands rgb444 to rgb888, derives data enable from blanking
 * and tracks odd and even lines from the sync edges
 */

`timescale 1ns/1ps

module video_line_stage (
    input  logic              clk_74a,
    input  logic              temp_reset,
    input  video_pkg::rgb_in_t core_rgb,
    input  logic              core_hs,
    input  logic              core_vs,
    input  logic              core_hb,
    input  logic              core_vb,
    video_if.source           pix
);
    import video_pkg::*;

    logic     prev_hs;
    logic     prev_vs;
    logic     line_odd;
    logic     odd_next;
    rgb_out_t rgb_wide;

    // new parity applies to the pixel of the edge itself
    always_comb begin
        if (core_vs && !prev_vs) begin
            odd_next = 1'b0;
        end else if (core_hs && !prev_hs) begin
            odd_next = ~line_odd;
        end else begin
            odd_next = line_odd;
        end
    end

    // nibble goes to the top of each channel
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            rgb_wide[c*CHAN_OUT_W +: CHAN_OUT_W] =
                {core_rgb[c*CHAN_IN_W +: CHAN_IN_W], {(CHAN_OUT_W-CHAN_IN_W){1'b0}}};
        end
    end

    //////////////////////////////////////////////////
    // stage registers

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            prev_hs  <= 1'b0;
            prev_vs  <= 1'b0;
            line_odd <= 1'b0;
            pix.hs   <= 1'b0;
            pix.vs   <= 1'b0;
            pix.de   <= 1'b0;
        end else begin
            prev_hs  <= core_hs;
            prev_vs  <= core_vs;
            line_odd <= odd_next;
            pix.hs   <= core_hs;
            pix.vs   <= core_vs;
            pix.de   <= ~(core_hb | core_vb);
        end
    end

    always_ff @(posedge clk_74a) begin
        pix.rgb <= rgb_wide;
    end

    assign pix.odd_line = line_odd;

endmodule

/* scanline_dim.sv */
/*
 * scanline darkening stage
 * dims odd-line pixels by the selected level and drives the video outputs
 */

`timescale 1ns/1ps

module scanline_dim (
    input  logic                       clk_74a,
    input  logic                       temp_reset,
    video_if.sink                      pix,
    input  video_pkg::scanline_level_e scanline_level,
    output video_pkg::rgb_out_t        video_rgb,
    output logic                       video_hs,
    output logic                       video_vs,
    output logic                       video_de
);
    import video_pkg::*;

    rgb_out_t rgb_dim;

    // one channel at the given level
    function automatic logic [CHAN_OUT_W-1:0] dim_chan(
        input logic [CHAN_OUT_W-1:0] x,
        input scanline_level_e       lvl
    );
        case (lvl)
            SCN_25:  dim_chan = x - (x >> 2);
            SCN_50:  dim_chan = x >> 1;
            SCN_75:  dim_chan = x >> 2;
            default: dim_chan = x;
        endcase
    endfunction

    always_comb begin
        rgb_dim = pix.rgb;
        // even lines pass untouched
        if (pix.odd_line) begin
            for (int c = 0; c < 3; c++) begin
                rgb_dim[c*CHAN_OUT_W +: CHAN_OUT_W] =
                    dim_chan(pix.rgb[c*CHAN_OUT_W +: CHAN_OUT_W], scanline_level);
            end
        end
    end

    //////////////////////////////////////////////////
    // output registers

    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end else begin
            video_hs <= pix.hs;
            video_vs <= pix.vs;
            video_de <= pix.de;
        end
    end

    always_ff @(posedge clk_74a) begin
        video_rgb <= rgb_dim;
    end

endmodule

/* pocket_core_shell.sv */
/*
 * pocket core shell
 * bridge settings, core reset hold, control panel merge and video path
 */

`timescale 1ns/1ps

module pocket_core_shell (
    input  logic                        clk_74a,
    input  logic                        temp_reset,
    // bridge bus
    input  core_ctrl_pkg::bridge_data_t bridge_addr,
    input  logic                        bridge_rd,
    input  logic                        bridge_wr,
    input  core_ctrl_pkg::bridge_data_t bridge_wr_data,
    output core_ctrl_pkg::bridge_data_t bridge_rd_data,
    // gamepads
    input  core_ctrl_pkg::bridge_data_t cont1_key,
    input  core_ctrl_pkg::bridge_data_t cont2_key,
    // core side
    input  video_pkg::rgb_in_t          core_rgb,
    input  logic                        core_hs,
    input  logic                        core_vs,
    input  logic                        core_hb,
    input  logic                        core_vb,
    output core_ctrl_pkg::bridge_data_t dip_word,
    output logic [7:0]                  core_mode,
    output logic                        core_run,
    output core_ctrl_pkg::panel_t       control_panel,
    // scaler side
    output video_pkg::rgb_out_t         video_rgb,
    output logic                        video_hs,
    output logic                        video_vs,
    output logic                        video_de
);
    import video_pkg::*;

    logic            soft_reset_req;
    scanline_level_e scanline_level;

    video_if pix_if ();

    //////////////////////////////////////////////////
    // settings and reset

    bridge_regs u_bridge_regs (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .core_run       (core_run),
        .bridge_rd_data (bridge_rd_data),
        .dip_word       (dip_word),
        .core_mode      (core_mode),
        .scanline_level (scanline_level),
        .soft_reset_req (soft_reset_req)
    );

    core_reset_timer u_core_reset_timer (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .soft_reset_req (soft_reset_req),
        .core_run       (core_run)
    );

    pad_merge u_pad_merge (
        .clk_74a       (clk_74a),
        .temp_reset    (temp_reset),
        .cont1_key     (cont1_key),
        .cont2_key     (cont2_key),
        .control_panel (control_panel)
    );

    //////////////////////////////////////////////////
    // video pipeline, two stages

    video_line_stage u_video_line_stage (
        .clk_74a    (clk_74a),
        .temp_reset (temp_reset),
        .core_rgb   (core_rgb),
        .core_hs    (core_hs),
        .core_vs    (core_vs),
        .core_hb    (core_hb),
        .core_vb    (core_vb),
        .pix        (pix_if)
    );

    scanline_dim u_scanline_dim (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .pix            (pix_if),
        .scanline_level (scanline_level),
        .video_rgb      (video_rgb),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .video_de       (video_de)
    );

endmodule

/* pocket_core_shell_sva.sv */
/*
 * pocket core shell assertions
 * bridge read data hold, soft reset response and blanking on video_de
 */

`timescale 1ns/1ps

module pocket_core_shell_sva (
    input logic                        clk_74a,
    input logic                        temp_reset,
    input core_ctrl_pkg::bridge_data_t bridge_addr,
    input logic                        bridge_rd,
    input logic                        bridge_wr,
    input core_ctrl_pkg::bridge_data_t bridge_rd_data,
    input logic                        core_run,
    input logic                        core_hb,
    input logic                        core_vb,
    input logic                        video_de
);
    import core_ctrl_pkg::*;

    int fail_count = 0;

    // read word moves only after a read strobe
    rd_data_held: assert property (@(posedge clk_74a) disable iff (temp_reset)
        !$stable(bridge_rd_data) |-> $past(bridge_rd))
    else begin
        fail_count++;
        $error("bridge_rd_data changed without a read");
    end

    // core stops soon after a reset or dip write
    run_drops: assert property (@(posedge clk_74a) disable iff (temp_reset)
        bridge_wr && (bridge_addr == REG_RESET || bridge_addr == REG_DIP)
        |-> ##[1:2] !core_run)
    else begin
        fail_count++;
        $error("core_run still high two cycles after a reset request");
    end

    // two stage latency on data enable
    de_blanked: assert property (@(posedge clk_74a) disable iff (temp_reset)
        (core_hb || core_vb) |-> ##2 !video_de)
    else begin
        fail_count++;
        $error("video_de high for a blanked pixel");
    end

endmodule

bind pocket_core_shell pocket_core_shell_sva shell_sva (.*);

/* tb_pocket_core_shell.sv */
/*
 * pocket core shell testbench
 * table-driven checks of the bridge registers, reset hold, pad merge
 * and the two-stage video path with scanline darkening
 */

`timescale 1ns/1ps

module tb_pocket_core_shell;
    import core_ctrl_pkg::*;
    import video_pkg::*;

    localparam int REG_N = 10;
    localparam int PAD_N = 14;
    localparam int PIX_N = 40;
    localparam int SEQ_N = 16;
    localparam int TIMEOUT_CYCLES = 8 + 3 * (CORE_RESET_HOLD + 10)
                                    + REG_N + PAD_N + PIX_N + 4 * SEQ_N + 200;

    // address and write data per row in order of use
    localparam logic [0:REG_N-1][63:0] REG_TAB = {
        {REG_DIP,       32'h1234_5678},
        {REG_MODE,      32'h0000_00A5},
        {REG_SCANLINES, 32'h0000_0002},
        {32'hF400_0000, 32'hDEAD_BEEF},
        {32'h0000_0010, 32'hFFFF_FFFF},
        {REG_MODE,      32'hCAFE_F00D},
        {REG_DIP,       32'h0000_0001},
        {REG_SCANLINES, 32'h8000_0003},
        {32'hF300_0004, 32'h5555_5555},
        {REG_DIP,       32'hFFFF_FFFF}
    };

    // pad 1 keys, pad 2 keys, expected active-low panel
    localparam logic [0:PAD_N-1][40:0] PAD_TAB = {
        {16'h0000, 16'h0000, 9'h1FF},
        {16'h0001, 16'h0000, 9'h1F7},
        {16'h0000, 16'h0002, 9'h1FB},
        {16'h0004, 16'h0008, 9'h1FC},
        {16'h8000, 16'h0000, 9'h1BF},
        {16'h0000, 16'h8000, 9'h17F},
        {16'h4000, 16'h0000, 9'h0FF},
        {16'h0000, 16'h4000, 9'h0FF},
        {16'h0020, 16'h0000, 9'h1EF},
        {16'h0000, 16'h0080, 9'h1DF},
        {16'hC0AF, 16'h0000, 9'h080},
        {16'h0050, 16'h3F00, 9'h1FF},
        {16'h0003, 16'h000C, 9'h1F0},
        {16'h8000, 16'h8000, 9'h13F}
    };

    // hs and vs per pixel for a frame start and a few lines
    localparam logic [0:SEQ_N-1][1:0] SYNC_SEQ = {
        2'b01, 2'b01, 2'b00, 2'b10, 2'b10, 2'b00, 2'b00, 2'b10,
        2'b00, 2'b10, 2'b10, 2'b00, 2'b11, 2'b01, 2'b10, 2'b00
    };

    logic         clk_74a;
    logic         temp_reset;
    bridge_data_t bridge_addr;
    logic         bridge_rd;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    bridge_data_t bridge_rd_data;
    bridge_data_t cont1_key;
    bridge_data_t cont2_key;
    rgb_in_t      core_rgb;
    logic         core_hs;
    logic         core_vs;
    logic         core_hb;
    logic         core_vb;
    bridge_data_t dip_word;
    logic [7:0]   core_mode;
    logic         core_run;
    panel_t       control_panel;
    rgb_out_t     video_rgb;
    logic         video_hs;
    logic         video_vs;
    logic         video_de;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    // host side copy of the settings registers
    bridge_data_t exp_dip;
    bridge_data_t exp_mode;
    bridge_data_t exp_scn;

    pocket_core_shell dut (.*);

    always #10 clk_74a = ~clk_74a;

    always @(posedge clk_74a) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic next_cycle();
        @(posedge clk_74a);
        #2;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input bridge_data_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        case (addr)
            REG_DIP:       exp_dip  = data;
            REG_MODE:      exp_mode = data;
            REG_SCANLINES: exp_scn  = data;
            default: ;
        endcase
        next_cycle();
        bridge_wr = 1'b0;
    endtask

    task automatic bus_read(input bridge_data_t addr, output bridge_data_t data);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        next_cycle();
        bridge_rd = 1'b0;
        data      = bridge_rd_data;
    endtask

    function automatic bridge_data_t expected_read(input bridge_data_t addr);
        case (addr)
            REG_DIP:       return exp_dip;
            REG_MODE:      return exp_mode;
            REG_SCANLINES: return exp_scn;
            default:       return '0;
        endcase
    endfunction

    // start counts the cycles already spent since the request
    task automatic wait_core_run(input int start);
        int           n;
        bridge_data_t rd;
        n = start;
        while ((n < 3 || core_run !== 1'b1) && n < CORE_RESET_HOLD + 10) begin
            if (n == 2) begin
                bridge_addr = REG_RESET;
                bridge_rd   = 1'b1;
            end
            next_cycle();
            n++;
            if (n == 2) begin
                check_value("core_run during hold", core_run, 0);
            end
            if (n == 3) begin
                bridge_rd = 1'b0;
                check_value("REG_RESET read during hold", bridge_rd_data, 0);
            end
        end
        if (n < CORE_RESET_HOLD || n > CORE_RESET_HOLD + 3) begin
            error_count++;
            $display("core_run was not back up inside the hold window, stopped at cycle %0d", n);
        end
        bus_read(REG_RESET, rd);
        check_value("REG_RESET read after hold", rd, 32'h1);
    endtask

    function automatic logic [7:0] dim_channel(input logic [7:0] x, input logic [1:0] lvl);
        case (lvl)
            2'd1:    return x - x / 4;
            2'd2:    return x / 2;
            2'd3:    return x / 4;
            default: return x;
        endcase
    endfunction

    // random pixels with random blanking or a sync sequence
    task automatic run_video(input int count, input bit use_seq);
        logic [26:0] expect_q [$];
        logic [26:0] item;
        rgb_in_t     px;
        rgb_out_t    wide;
        logic        hs, vs, hb, vb;
        logic        prev_hs, prev_vs, odd;
        int          i;
        prev_hs = 1'b0;
        prev_vs = 1'b0;
        odd     = 1'b0;
        for (i = 0; i <= count; i++) begin
            if (i < count) begin
                px = rgb_in_t'($urandom);
                if (use_seq) begin
                    {hs, vs} = SYNC_SEQ[i];
                    hb = 1'b0;
                    vb = 1'b0;
                end else begin
                    hs = 1'b0;
                    vs = 1'b0;
                    {hb, vb} = 2'($urandom);
                end
                // vs edge clears and hs edge flips for this same pixel
                if (vs && !prev_vs) begin
                    odd = 1'b0;
                end else if (hs && !prev_hs) begin
                    odd = !odd;
                end
                prev_hs = hs;
                prev_vs = vs;
                wide = {px[11:8], 4'h0, px[7:4], 4'h0, px[3:0], 4'h0};
                if (odd) begin
                    wide = {dim_channel(wide[23:16], exp_scn[1:0]),
                            dim_channel(wide[15:8], exp_scn[1:0]),
                            dim_channel(wide[7:0], exp_scn[1:0])};
                end
                expect_q.push_back({!(hb || vb), hs, vs, wide});
                core_rgb = px;
                core_hs  = hs;
                core_vs  = vs;
                core_hb  = hb;
                core_vb  = vb;
            end
            next_cycle();
            if (i > 0) begin
                item = expect_q.pop_front();
                check_value("video_rgb", video_rgb, item[23:0]);
                check_value("video_vs", video_vs, item[24]);
                check_value("video_hs", video_hs, item[25]);
                check_value("video_de", video_de, item[26]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        bridge_data_t rd;
        panel_t       prev_panel;
        int           i;
        clk_74a        = 1'b0;
        temp_reset     = 1'b1;
        bridge_addr    = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        // keys pressed and sync active while reset is held
        cont1_key      = '1;
        cont2_key      = '1;
        core_rgb       = '0;
        core_hs        = 1'b1;
        core_vs        = 1'b1;
        core_hb        = 1'b0;
        core_vb        = 1'b0;
        exp_dip        = '0;
        exp_mode       = '0;
        exp_scn        = '0;
        void'($urandom(32'h5345));

        repeat (8) next_cycle();
        check_value("bridge_rd_data after reset", bridge_rd_data, 0);
        check_value("control_panel after reset", control_panel, 9'h1FF);
        check_value("video_de after reset", video_de, 0);
        check_value("video_hs after reset", video_hs, 0);
        check_value("video_vs after reset", video_vs, 0);
        check_value("core_run after reset", core_run, 0);
        check_value("dip_word after reset", dip_word, 0);
        check_value("core_mode after reset", core_mode, 0);
        temp_reset = 1'b0;
        cont1_key  = '0;
        cont2_key  = '0;
        core_hs    = 1'b0;
        core_vs    = 1'b0;
        wait_core_run(0);

        // soft reset from the reset and dip registers
        bus_write(REG_RESET, 32'h1);
        wait_core_run(1);
        bus_write(REG_DIP, 32'h0000_00C3);
        wait_core_run(1);
        check_value("dip_word", dip_word, exp_dip);

        for (i = 0; i < REG_N; i++) begin
            bus_write(REG_TAB[i][63:32], REG_TAB[i][31:0]);
            check_value("dip_word", dip_word, exp_dip);
            check_value("core_mode", core_mode, exp_mode[7:0]);
            bus_read(REG_TAB[i][63:32], rd);
            check_value("register readback", rd, expected_read(REG_TAB[i][63:32]));
        end
        bus_read(REG_DIP, rd);
        check_value("REG_DIP final", rd, exp_dip);
        bus_read(REG_MODE, rd);
        check_value("REG_MODE final", rd, exp_mode);
        bus_read(REG_SCANLINES, rd);
        check_value("REG_SCANLINES final", rd, exp_scn);

        prev_panel = 9'h1FF;
        for (i = 0; i < PAD_N; i++) begin
            cont1_key = {16'h0000, PAD_TAB[i][40:25]};
            cont2_key = {16'h0000, PAD_TAB[i][24:9]};
            // panel keeps the previous word until the next edge
            #1;
            check_value("control_panel before edge", control_panel, prev_panel);
            next_cycle();
            check_value("control_panel", control_panel, PAD_TAB[i][8:0]);
            prev_panel = PAD_TAB[i][8:0];
        end
        cont1_key = '0;
        cont2_key = '0;

        bus_write(REG_SCANLINES, 32'h0);
        run_video(PIX_N, 1'b0);
        // upper bits of the scanline word are don't care
        for (i = 0; i < 4; i++) begin
            bus_write(REG_SCANLINES, 32'hABCD_0000 | i);
            run_video(SEQ_N, 1'b1);
        end

        $display("checks: %0d, check errors: %0d, assertion errors: %0d",
                 check_count, error_count, dut.shell_sva.fail_count);
        if (error_count == 0 && dut.shell_sva.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* files.f */
core_ctrl_pkg.sv
video_pkg.sv
video_if.sv
bridge_regs.sv
core_reset_timer.sv
pad_merge.sv
video_line_stage.sv
scanline_dim.sv
pocket_core_shell.sv
pocket_core_shell_sva.sv
tb_pocket_core_shell.sv

/* Bender.yml */
package:
  name: pocket_core_shell

sources:
  - core_ctrl_pkg.sv
  - video_pkg.sv
  - video_if.sv
  - bridge_regs.sv
  - core_reset_timer.sv
  - pad_merge.sv
  - video_line_stage.sv
  - scanline_dim.sv
  - pocket_core_shell.sv
  - target: test
    files:
      - pocket_core_shell_sva.sv
      - tb_pocket_core_shell.sv
